// ==== backend.f ====
+incdir+.
pipeline_types.sv
stable_counter.sv
regfile.sv
decoder.sv
execute.sv
ctrl.sv
backend_top.sv
tb_backend_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_backend_top -f backend.f -o sim_tb

sim_out=$(./obj_dir/sim_tb 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// ==== tb_backend_top.sv ====
`timescale 1ns/1ps
`include "backend_settings.svh"

module tb_backend_top;

    localparam int          PROG_WORDS     = 64;
    localparam int          HALT_START     = 56;
    localparam logic [31:0] PROG_BYTES     = 32'd256;
    localparam int          RESET_CYCLES   = 2;
    localparam int          TIMEOUT_CYCLES = 3 * PROG_WORDS + RESET_CYCLES;
    localparam logic [31:0] HALT_NOP       = 32'h03400000;

    logic                      clk = 1'b0;
    logic                      arst_n_i;
    logic                      inst_valid_i;
    logic [`REG_WIDTH-1:0]     pc_i;
    logic [`REG_WIDTH-1:0]     inst_i;
    logic                      flush_o;
    logic                      pause_o;
    logic [`REG_WIDTH-1:0]     new_pc_o;
    pipeline_types::wb_debug_t commit_o;
    logic [`TIMER_WIDTH-1:0]   timer_64_o;

    logic [31:0]               prog_mem [PROG_WORDS];
    logic [31:0]               model_regs [`REG_COUNT];
    logic [31:0]               lfsr_state;

    pipeline_types::wb_debug_t exp_q [$];
    int                        due_q [$];

    // fetch side
    logic [31:0]               fetch_pc;
    logic                      offered;
    pipeline_types::wb_debug_t new_rec;
    logic                      taken;
    logic [31:0]               target;
    int                        edge_cnt;
    int                        flush_edge;
    logic [31:0]               exp_target;

    // sampled mid-cycle
    logic                      seen_flush;
    logic [31:0]               seen_new_pc;
    logic [63:0]               seen_timer;
    logic                      timer_live;

    pipeline_types::wb_debug_t exp_rec;
    int                        exp_due;
    logic                      exp_flush;
    int                        cycle_cnt;

    backend_top i_backend_top (
        .clk,
        .arst_n_i,
        .inst_valid_i,
        .pc_i,
        .inst_i,
        .flush_o,
        .pause_o,
        .new_pc_o,
        .commit_o,
        .timer_64_o
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h80200003;
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = galois_step(lfsr_state);
        end
        return val;
    endfunction

    // registers limited to r0..r7 so dependences are frequent
    function automatic logic [31:0] gen_word();
        logic [31:0] kind;
        logic [31:0] rd;
        logic [31:0] rj;
        logic [31:0] rk;
        logic [31:0] fld;
        kind = take_bits(4);
        rd = take_bits(3);
        rj = take_bits(3);
        rk = take_bits(3);
        case (kind[3:0])
            4'd0, 4'd1:   return {`OPC_ADD_W, rk[4:0], rj[4:0], rd[4:0]};
            4'd2, 4'd14:  return {`OPC_SUB_W, rk[4:0], rj[4:0], rd[4:0]};
            4'd3:         return {`OPC_AND, rk[4:0], rj[4:0], rd[4:0]};
            4'd4:         return {`OPC_OR, rk[4:0], rj[4:0], rd[4:0]};
            4'd5, 4'd15:  return {`OPC_XOR, rk[4:0], rj[4:0], rd[4:0]};
            4'd6, 4'd7: begin
                fld = take_bits(12);
                return {`OPC_ADDI_W, fld[11:0], rj[4:0], rd[4:0]};
            end
            4'd8, 4'd9: begin
                fld = take_bits(20);
                return {`OPC_LU12I_W, fld[19:0], rd[4:0]};
            end
            4'd10, 4'd11: begin
                // forward by 1 to 4 words with operands from r0..r3
                fld = take_bits(2);
                return {`OPC_BEQ, 16'(fld + 32'd1), 3'b000, rj[1:0], 3'b000, rd[1:0]};
            end
            4'd12:        return {`OPC_RDCNTVL_W, 5'd0, rd[4:0]};
            default: begin
                fld = take_bits(16);
                return {16'hffff, fld[15:0]};
            end
        endcase
    endfunction

    // architectural model of one instruction
    function automatic pipeline_types::wb_debug_t ref_exec(
        input  logic [31:0] pc,
        input  logic [31:0] inst,
        input  logic [31:0] cnt_lo,
        output logic        br_taken,
        output logic [31:0] br_target
    );
        pipeline_types::wb_debug_t rec;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        wr;
        rd = inst[4:0];
        a = model_regs[inst[9:5]];
        b = model_regs[inst[14:10]];
        res = '0;
        wr = 1'b1;
        br_taken = 1'b0;
        br_target = pc + {{14{inst[25]}}, inst[25:10], 2'b00};
        if (inst[31:15] == `OPC_ADD_W)
            res = a + b;
        else if (inst[31:15] == `OPC_SUB_W)
            res = a - b;
        else if (inst[31:15] == `OPC_AND)
            res = a & b;
        else if (inst[31:15] == `OPC_OR)
            res = a | b;
        else if (inst[31:15] == `OPC_XOR)
            res = a ^ b;
        else if (inst[31:22] == `OPC_ADDI_W)
            res = a + {{20{inst[21]}}, inst[21:10]};
        else if (inst[31:25] == `OPC_LU12I_W)
            res = {inst[24:5], 12'h000};
        else if (inst[31:26] == `OPC_BEQ) begin
            wr = 1'b0;
            br_taken = (a == model_regs[rd]);
        end else if (inst[31:10] == `OPC_RDCNTVL_W)
            res = cnt_lo;
        else
            wr = 1'b0;
        if (rd == 5'd0)
            wr = 1'b0;
        if (wr)
            model_regs[rd] = res;
        rec = '0;
        rec.valid = 1'b1;
        rec.pc = pc;
        rec.inst = inst;
        rec.rf_wen = wr;
        rec.rf_wnum = rd;
        rec.rf_wdata = res;
        return rec;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, want);
            stop_with_failure("value mismatch");
        end
    endtask

    initial begin
        arst_n_i = 1'b0;
        inst_valid_i = 1'b0;
        pc_i = '0;
        inst_i = '0;
        lfsr_state = 32'h6cd98ef4;
        fetch_pc = '0;
        offered = 1'b0;
        edge_cnt = 0;
        flush_edge = -1;
        exp_target = '0;
        for (int i = 0; i < `REG_COUNT; i++)
            model_regs[i] = '0;
        for (int i = 0; i < PROG_WORDS; i++)
            prog_mem[i] = (i < HALT_START) ? gen_word() : HALT_NOP;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n_i <= 1'b1;
        while (offered || fetch_pc < PROG_BYTES || due_q.size() != 0) begin
            @(posedge clk);
            edge_cnt++;
            if (seen_flush) begin
                // offered word is dropped and one bubble covers the refill
                inst_valid_i <= 1'b0;
                fetch_pc = seen_new_pc;
                offered = 1'b0;
            end else begin
                if (offered) begin
                    new_rec = ref_exec(fetch_pc, prog_mem[fetch_pc[7:2]],
                                       seen_timer[31:0] + 32'd1, taken, target);
                    exp_q.push_back(new_rec);
                    due_q.push_back(edge_cnt + 1);
                    if (taken) begin
                        flush_edge = edge_cnt;
                        exp_target = target;
                    end
                    fetch_pc = fetch_pc + 32'd4;
                end
                offered = (fetch_pc < PROG_BYTES);
                inst_valid_i <= offered;
                pc_i <= fetch_pc;
                inst_i <= offered ? prog_mem[fetch_pc[7:2]] : '0;
            end
        end
        // a couple of idle edges to catch stray commits
        repeat (2) begin
            @(posedge clk);
            edge_cnt++;
        end
        $display("test passed");
        $finish;
    end

    always @(negedge clk) begin
        if (!arst_n_i) begin
            check_value("commit_o.valid", 64'(commit_o.valid), 64'd0);
            check_value("flush_o", 64'(flush_o), 64'd0);
            check_value("pause_o", 64'(pause_o), 64'd0);
            check_value("timer_64_o", timer_64_o, 64'd0);
            timer_live = 1'b0;
        end else begin
            if (timer_live)
                check_value("timer_64_o", timer_64_o, seen_timer + 64'd1);
            timer_live = 1'b1;
            check_value("pause_o", 64'(pause_o), 64'(seen_flush));
            exp_flush = (flush_edge == edge_cnt);
            check_value("flush_o", 64'(flush_o), 64'(exp_flush));
            if (exp_flush)
                check_value("new_pc_o", 64'(new_pc_o), 64'(exp_target));
            if (commit_o.valid) begin
                if (exp_q.size() == 0) begin
                    stop_with_failure("commit seen with no instruction outstanding");
                end else begin
                    exp_rec = exp_q.pop_front();
                    exp_due = due_q.pop_front();
                    check_value("commit edge", 64'(edge_cnt), 64'(exp_due));
                    check_value("commit_o.pc", 64'(commit_o.pc), 64'(exp_rec.pc));
                    check_value("commit_o.inst", 64'(commit_o.inst), 64'(exp_rec.inst));
                    check_value("commit_o.rf_wen", 64'(commit_o.rf_wen),
                                64'(exp_rec.rf_wen));
                    if (exp_rec.rf_wen) begin
                        check_value("commit_o.rf_wnum", 64'(commit_o.rf_wnum),
                                    64'(exp_rec.rf_wnum));
                        check_value("commit_o.rf_wdata", 64'(commit_o.rf_wdata),
                                    64'(exp_rec.rf_wdata));
                    end
                end
            end else if (due_q.size() != 0 && due_q[0] <= edge_cnt) begin
                stop_with_failure("an accepted instruction did not commit in time");
            end
        end
        seen_flush = flush_o;
        seen_new_pc = new_pc_o;
        seen_timer = timer_64_o;
    end

    initial begin
        cycle_cnt = 0;
        seen_flush = 1'b0;
        seen_new_pc = '0;
        seen_timer = '0;
        timer_live = 1'b0;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES)
            stop_with_failure("timeout, the program did not drain in time");
    end

endmodule

// ==== backend_top.sv ====
`timescale 1ns/1ps
`include "backend_settings.svh"

module backend_top (
    input  logic                      clk,
    input  logic                      arst_n_i,

    // from instbuffer
    input  logic                      inst_valid_i,
    input  logic [`REG_WIDTH-1:0]     pc_i,
    input  logic [`REG_WIDTH-1:0]     inst_i,

    // to pc
    output logic                      flush_o,
    output logic                      pause_o,
    output logic [`REG_WIDTH-1:0]     new_pc_o,

    // debug
    output pipeline_types::wb_debug_t commit_o,
    output logic [`TIMER_WIDTH-1:0]   timer_64_o
);

    // decoder to execute
    pipeline_types::dispatch_ex_t ex_i;

    // execute result, also the regfile write port
    pipeline_types::reg_forward_t ex_fwd;

    logic [`REG_ADDR_WIDTH-1:0]   rf_raddr1;
    logic [`REG_ADDR_WIDTH-1:0]   rf_raddr2;
    logic [`REG_WIDTH-1:0]        rf_rdata1;
    logic [`REG_WIDTH-1:0]        rf_rdata2;

    logic                         branch_flush;
    logic [`REG_WIDTH-1:0]        branch_target;

    logic [`TIMER_WIDTH-1:0]      cnt;

    decoder u_decoder (
        .clk,
        .arst_n_i,
        .flush_i      (flush_o),
        .pause_i      (pause_o),
        .inst_valid_i,
        .pc_i,
        .inst_i,
        .ex_fwd_i     (ex_fwd),
        .rf_raddr1_o  (rf_raddr1),
        .rf_raddr2_o  (rf_raddr2),
        .rf_rdata1_i  (rf_rdata1),
        .rf_rdata2_i  (rf_rdata2),
        .ex_o         (ex_i)
    );

    execute u_execute (
        .clk,
        .arst_n_i,
        .ex_i,
        .cnt_i           (cnt),
        .ex_fwd_o        (ex_fwd),
        .branch_flush_o  (branch_flush),
        .branch_target_o (branch_target),
        .commit_o
    );

    regfile u_regfile (
        .clk,
        .arst_n_i,
        .wr_i     (ex_fwd),
        .raddr1_i (rf_raddr1),
        .raddr2_i (rf_raddr2),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    ctrl u_ctrl (
        .clk,
        .arst_n_i,
        .branch_flush_i  (branch_flush),
        .branch_target_i (branch_target),
        .flush_o,
        .pause_o,
        .new_pc_o
    );

    stable_counter u_counter (
        .clk,
        .arst_n_i,
        .cnt_o (cnt)
    );

    assign timer_64_o = cnt;

endmodule

// ==== ctrl.sv ====
`timescale 1ns/1ps
`include "backend_settings.svh"

module ctrl (
    input  logic                  clk,
    input  logic                  arst_n_i,

    // from execute
    input  logic                  branch_flush_i,
    input  logic [`REG_WIDTH-1:0] branch_target_i,

    output logic                  flush_o,
    output logic                  pause_o,
    output logic [`REG_WIDTH-1:0] new_pc_o
);

    pipeline_types::ctrl_state_t state_q;
    pipeline_types::ctrl_state_t state_d;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            pipeline_types::CTRL_RUN: begin
                if (branch_flush_i) begin
                    state_d = pipeline_types::CTRL_REFILL;
                end
            end
            pipeline_types::CTRL_REFILL: begin
                // one bubble while fetch restarts
                state_d = pipeline_types::CTRL_RUN;
            end
            default: state_d = pipeline_types::CTRL_RUN;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= pipeline_types::CTRL_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    assign flush_o  = branch_flush_i;
    assign new_pc_o = branch_target_i;
    assign pause_o  = (state_q == pipeline_types::CTRL_REFILL);

    // decoder is empty during refill, so no beq can resolve
    a_no_flush_in_refill: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (state_q == pipeline_types::CTRL_REFILL) |-> !flush_o
    ) else $error("flush raised during refill");

endmodule

// ==== execute.sv ====
`timescale 1ns/1ps
`include "backend_settings.svh"

module execute (
    input  logic                         clk,
    input  logic                         arst_n_i,

    input  pipeline_types::dispatch_ex_t ex_i,
    input  logic [`TIMER_WIDTH-1:0]      cnt_i,

    output pipeline_types::reg_forward_t ex_fwd_o,

    // to ctrl
    output logic                         branch_flush_o,
    output logic [`REG_WIDTH-1:0]        branch_target_o,

    output pipeline_types::wb_debug_t    commit_o
);

    logic [`REG_WIDTH-1:0] alu_result;
    logic                  src_equal;

    always_comb begin
        unique case (ex_i.op)
            pipeline_types::ALU_ADD:   alu_result = ex_i.src1 + ex_i.src2;
            pipeline_types::ALU_SUB:   alu_result = ex_i.src1 - ex_i.src2;
            pipeline_types::ALU_AND:   alu_result = ex_i.src1 & ex_i.src2;
            pipeline_types::ALU_OR:    alu_result = ex_i.src1 | ex_i.src2;
            pipeline_types::ALU_XOR:   alu_result = ex_i.src1 ^ ex_i.src2;
            pipeline_types::ALU_LUI:   alu_result = ex_i.imm << 12;
            pipeline_types::ALU_RDCNT: alu_result = cnt_i[`REG_WIDTH-1:0];
            default:                   alu_result = '0;
        endcase
    end

    // branch resolution
    assign src_equal       = (ex_i.src1 == ex_i.src2);
    assign branch_flush_o  = ex_i.valid && (ex_i.op == pipeline_types::ALU_BEQ) && src_equal;
    assign branch_target_o = ex_i.pc + (ex_i.imm << 2);

    always_comb begin
        ex_fwd_o.wen   = ex_i.valid && ex_i.rf_wen;
        ex_fwd_o.waddr = ex_i.rf_wnum;
        ex_fwd_o.wdata = alu_result;
    end

    // commit record registered one cycle after execute
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            commit_o <= '0;
        end else begin
            commit_o.valid    <= ex_i.valid;
            commit_o.pc       <= ex_i.pc;
            commit_o.inst     <= ex_i.inst;
            commit_o.rf_wen   <= ex_fwd_o.wen;
            commit_o.rf_wnum  <= ex_i.rf_wnum;
            commit_o.rf_wdata <= alu_result;
        end
    end

    // a redirecting beq still retires without a register write
    a_flush_beq_retires: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        branch_flush_o |=> (commit_o.valid && !commit_o.rf_wen)
    ) else $error("branch flush without a committing beq");

    // younger instruction must be dropped by the decoder
    a_flush_drops_next: assert property (
        @(posedge clk) disable iff (!arst_n_i) branch_flush_o |=> !ex_i.valid
    ) else $error("instruction after taken beq reached execute");

endmodule

// ==== decoder.sv ====
`timescale 1ns/1ps
`include "backend_settings.svh"

module decoder (
    input  logic                        clk,
    input  logic                        arst_n_i,

    input  logic                        flush_i,
    input  logic                        pause_i,

    // from instbuffer
    input  logic                        inst_valid_i,
    input  logic [`REG_WIDTH-1:0]       pc_i,
    input  logic [`REG_WIDTH-1:0]       inst_i,

    input  pipeline_types::reg_forward_t ex_fwd_i,

    // regfile read ports
    output logic [`REG_ADDR_WIDTH-1:0]  rf_raddr1_o,
    output logic [`REG_ADDR_WIDTH-1:0]  rf_raddr2_o,
    input  logic [`REG_WIDTH-1:0]       rf_rdata1_i,
    input  logic [`REG_WIDTH-1:0]       rf_rdata2_i,

    output pipeline_types::dispatch_ex_t ex_o
);

    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`REG_ADDR_WIDTH-1:0] rj;
    logic [`REG_ADDR_WIDTH-1:0] rk;
    logic                       is_beq;
    logic [`REG_WIDTH-1:0]      src1;
    logic [`REG_WIDTH-1:0]      src2;
    pipeline_types::dispatch_ex_t dec;

    function automatic logic [`REG_WIDTH-1:0] fwd_sel(
        input logic [`REG_ADDR_WIDTH-1:0] addr,
        input logic [`REG_WIDTH-1:0]      rf_data,
        input pipeline_types::reg_forward_t fwd
    );
        if (fwd.wen && fwd.waddr != '0 && fwd.waddr == addr) begin
            return fwd.wdata;
        end
        return rf_data;
    endfunction

    assign rd     = inst_i[4:0];
    assign rj     = inst_i[9:5];
    assign rk     = inst_i[14:10];
    assign is_beq = (inst_i[31:26] == `OPC_BEQ);

    // beq compares rj against rd
    assign rf_raddr1_o = rj;
    assign rf_raddr2_o = is_beq ? rd : rk;

    assign src1 = fwd_sel(rf_raddr1_o, rf_rdata1_i, ex_fwd_i);
    assign src2 = fwd_sel(rf_raddr2_o, rf_rdata2_i, ex_fwd_i);

    always_comb begin
        dec         = '0;
        dec.valid   = inst_valid_i;
        dec.pc      = pc_i;
        dec.inst    = inst_i;
        dec.op      = pipeline_types::ALU_NOP;
        dec.src1    = src1;
        dec.src2    = src2;
        dec.rf_wnum = rd;
        if (inst_i[31:15] == `OPC_ADD_W) begin
            dec.op     = pipeline_types::ALU_ADD;
            dec.rf_wen = 1'b1;
        end else if (inst_i[31:15] == `OPC_SUB_W) begin
            dec.op     = pipeline_types::ALU_SUB;
            dec.rf_wen = 1'b1;
        end else if (inst_i[31:15] == `OPC_AND) begin
            dec.op     = pipeline_types::ALU_AND;
            dec.rf_wen = 1'b1;
        end else if (inst_i[31:15] == `OPC_OR) begin
            dec.op     = pipeline_types::ALU_OR;
            dec.rf_wen = 1'b1;
        end else if (inst_i[31:15] == `OPC_XOR) begin
            dec.op     = pipeline_types::ALU_XOR;
            dec.rf_wen = 1'b1;
        end else if (inst_i[31:22] == `OPC_ADDI_W) begin
            // immediate replaces rk operand
            dec.op     = pipeline_types::ALU_ADD;
            dec.imm    = {{20{inst_i[21]}}, inst_i[21:10]};
            dec.src2   = dec.imm;
            dec.rf_wen = 1'b1;
        end else if (inst_i[31:25] == `OPC_LU12I_W) begin
            dec.op     = pipeline_types::ALU_LUI;
            dec.imm    = {{12{inst_i[24]}}, inst_i[24:5]};
            dec.rf_wen = 1'b1;
        end else if (is_beq) begin
            dec.op     = pipeline_types::ALU_BEQ;
            dec.imm    = {{16{inst_i[25]}}, inst_i[25:10]};
        end else if (inst_i[31:10] == `OPC_RDCNTVL_W) begin
            dec.op     = pipeline_types::ALU_RDCNT;
            dec.rf_wen = 1'b1;
        end
        // r0 is never written
        if (rd == '0) begin
            dec.rf_wen = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_o <= '0;
        end else begin
            ex_o <= dec;
            if (flush_i || pause_i) begin
                ex_o.valid <= 1'b0;
            end
        end
    end

    // instbuffer holds off for the refill cycle
    a_no_issue_in_pause: assert property (
        @(posedge clk) disable iff (!arst_n_i) pause_i |-> !inst_valid_i
    ) else $error("instruction offered while pause is high");

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ps
`include "backend_settings.svh"

module regfile (
    input  logic                         clk,
    input  logic                         arst_n_i,

    input  pipeline_types::reg_forward_t wr_i,

    input  logic [`REG_ADDR_WIDTH-1:0]   raddr1_i,
    input  logic [`REG_ADDR_WIDTH-1:0]   raddr2_i,
    output logic [`REG_WIDTH-1:0]        rdata1_o,
    output logic [`REG_WIDTH-1:0]        rdata2_o
);

    logic [`REG_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.wen && wr_i.waddr != '0) begin
            regs[wr_i.waddr] <= wr_i.wdata;
        end
    end

    // asynchronous read, r0 is hard zero
    always_comb begin
        if (raddr1_i == '0) begin
            rdata1_o = '0;
        end else begin
            rdata1_o = regs[raddr1_i];
        end
        if (raddr2_i == '0) begin
            rdata2_o = '0;
        end else begin
            rdata2_o = regs[raddr2_i];
        end
    end

endmodule

// ==== stable_counter.sv ====
`timescale 1ns/1ps
`include "backend_settings.svh"

module stable_counter (
    input  logic                    clk,
    input  logic                    arst_n_i,

    output logic [`TIMER_WIDTH-1:0] cnt_o
);

    // free running, wraps at 2^64
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_o <= '0;
        end else begin
            cnt_o <= cnt_o + 1'b1;
        end
    end

endmodule

// ==== pipeline_types.sv ====
`include "backend_settings.svh"

package pipeline_types;

    typedef enum logic [3:0] {
        ALU_NOP   = 4'd0,
        ALU_ADD   = 4'd1,
        ALU_SUB   = 4'd2,
        ALU_AND   = 4'd3,
        ALU_OR    = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_LUI   = 4'd6,
        ALU_BEQ   = 4'd7,
        ALU_RDCNT = 4'd8
    } alu_op_t;

    typedef enum logic {
        CTRL_RUN    = 1'b0,
        CTRL_REFILL = 1'b1
    } ctrl_state_t;

    // decoder register, read by execute
    typedef struct packed {
        logic                         valid;
        logic [`REG_WIDTH-1:0]        pc;
        logic [`REG_WIDTH-1:0]        inst;
        alu_op_t                      op;
        logic [`REG_WIDTH-1:0]        src1;
        logic [`REG_WIDTH-1:0]        src2;
        logic [`REG_WIDTH-1:0]        imm;
        logic                         rf_wen;
        logic [`REG_ADDR_WIDTH-1:0]   rf_wnum;
    } dispatch_ex_t;

    // execute result, forwarding source and regfile write port
    typedef struct packed {
        logic                         wen;
        logic [`REG_ADDR_WIDTH-1:0]   waddr;
        logic [`REG_WIDTH-1:0]        wdata;
    } reg_forward_t;

    // commit record for difftest
    typedef struct packed {
        logic                         valid;
        logic [`REG_WIDTH-1:0]        pc;
        logic [`REG_WIDTH-1:0]        inst;
        logic                         rf_wen;
        logic [`REG_ADDR_WIDTH-1:0]   rf_wnum;
        logic [`REG_WIDTH-1:0]        rf_wdata;
    } wb_debug_t;

endpackage

// ==== backend_settings.svh ====
`ifndef BACKEND_SETTINGS_SVH
`define BACKEND_SETTINGS_SVH

// datapath widths
`define REG_WIDTH       32
`define REG_ADDR_WIDTH  5
`define REG_COUNT       32
`define TIMER_WIDTH     64

// 3R type, matched on inst[31:15]
`define OPC_ADD_W       17'h00020
`define OPC_SUB_W       17'h00022
`define OPC_AND         17'h00029
`define OPC_OR          17'h0002a
`define OPC_XOR         17'h0002b

// 2RI12, matched on inst[31:22]
`define OPC_ADDI_W      10'h00a

// 1RI20, matched on inst[31:25]
`define OPC_LU12I_W     7'h0a

// 2RI16, matched on inst[31:26]
`define OPC_BEQ         6'h16

// matched on inst[31:10], rd is the destination
`define OPC_RDCNTVL_W   22'h000018

`endif
